// ==== hdmi_island_config.svh ====
`ifndef HDMI_ISLAND_CONFIG_SVH
`define HDMI_ISLAND_CONFIG_SVH

`default_nettype none

// data island packet geometry, fixed by the HDMI specification
`define ISLAND_CYCLES 32
`define SUBPACKET_DATA_BITS 56
`define HEADER_DATA_BITS 24

// AVI InfoFrame header bytes (type, version, length)
`define AVI_TYPE 8'h82
`define AVI_VERSION 8'h02
`define AVI_LENGTH 8'd13

// BCH(64,56) and BCH(32,24) feedback mask, applied LSB first
`define BCH_POLY 8'h83

`default_nettype wire

`endif

// ==== hdmi_island_pkg.sv ====
`default_nettype none

package hdmi_island_pkg;

    // packet type byte, sent as header byte 0
    typedef enum logic [7:0]
    {
        PKT_NULL = 8'h00,
        PKT_AVI  = 8'h82
    } packet_type_e;

    // packet held by the selector for the current island slot
    // SEL_IDLE only exists between reset and the first selection
    typedef enum logic [1:0]
    {
        SEL_IDLE,
        SEL_NULL,
        SEL_AVI
    } selector_state_e;

endpackage

`default_nettype wire

// ==== island_packet_if.sv ====
`include "hdmi_island_config.svh"
`default_nettype none
`timescale 1ns/1ps

interface island_packet_if;

    // packet contents, stable for a whole packet
    logic [`HEADER_DATA_BITS-1:0]                header;
    logic [3:0][`SUBPACKET_DATA_BITS-1:0]        sub;

    // island enable level and the end-of-packet pulse
    logic                                        enable;
    logic                                        packet_next;

    modport source
    (
        output header,
        output sub,
        input  enable,
        input  packet_next
    );

    modport sink
    (
        input  header,
        input  sub,
        input  enable,
        output packet_next
    );

endinterface

`default_nettype wire

// ==== packet_selector.sv ====
`include "hdmi_island_config.svh"
`default_nettype none
`timescale 1ns/1ps

module packet_selector
(
    input  logic                   clk_pixel,
    input  logic                   arst_n,
    input  logic                   avi_request,
    input  logic [6:0]             vic,
    input  logic [1:0]             color_format,
    island_packet_if.source        pkt
);

    hdmi_island_pkg::selector_state_e state;
    hdmi_island_pkg::packet_type_e    pkt_type;

    logic       pending;
    logic       pick;
    logic [6:0] vic_req;
    logic [1:0] cf_req;
    logic [6:0] vic_q;
    logic [1:0] cf_q;
    logic [7:0] pb1;
    logic [7:0] pb4;
    logic [7:0] checksum;

    // a new packet is chosen at each boundary, and once after reset
    // before the first enabled cycle so that no packet is cut short
    assign pick = pkt.packet_next ||
                  ((state == hdmi_island_pkg::SEL_IDLE) && !pkt.enable);

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state   <= hdmi_island_pkg::SEL_IDLE;
            pending <= 1'b0;
        end
        else
        begin
            // a request arriving on a pick cycle stays pending for the next slot
            pending <= avi_request || (pending && !pick);
            if (pick)
                state <= pending ? hdmi_island_pkg::SEL_AVI : hdmi_island_pkg::SEL_NULL;
        end
    end

    // the request fields are sampled with the request, then frozen for the packet
    always_ff @(posedge clk_pixel)
    begin
        if (avi_request)
        begin
            vic_req <= vic;
            cf_req  <= color_format;
        end
        if (pick && pending)
        begin
            vic_q <= vic_req;
            cf_q  <= cf_req;
        end
    end

    // PB1 carries Y1:Y0 in bits 6:5, PB4 carries the VIC
    assign pb1 = {1'b0, cf_q, 5'd0};
    assign pb4 = {1'b0, vic_q};

    // all bytes of the InfoFrame, checksum included, must sum to zero
    assign checksum = 8'd0 - (`AVI_TYPE + `AVI_VERSION + `AVI_LENGTH + pb1 + pb4);

    always_comb
    begin
        pkt_type   = hdmi_island_pkg::PKT_NULL;
        pkt.header = '0;
        pkt.sub    = '0;
        if (state == hdmi_island_pkg::SEL_AVI)
        begin
            pkt_type   = hdmi_island_pkg::PKT_AVI;
            pkt.header = {`AVI_LENGTH, `AVI_VERSION, pkt_type};
            // subpacket 0 holds PB0 to PB6, the remaining payload bytes are zero
            pkt.sub[0] = {8'd0, 8'd0, pb4, 8'd0, 8'd0, pb1, checksum};
        end
    end

endmodule

`default_nettype wire

// ==== island_serializer.sv ====
`include "hdmi_island_config.svh"
`default_nettype none
`timescale 1ns/1ps

module island_serializer
(
    input  logic                 clk_pixel,
    input  logic                 arst_n,
    island_packet_if.sink        pkt,
    output logic [8:0]           data
);

    localparam logic [4:0] LAST_K    = 5'(`ISLAND_CYCLES - 1);
    localparam logic [4:0] HDR_ECC_K = 5'(`HEADER_DATA_BITS);
    localparam logic [4:0] SUB_ECC_K = 5'(`SUBPACKET_DATA_BITS / 2);

    logic [4:0]       k;
    logic [3:0][7:0]  ecc_sub;
    logic [7:0]       ecc_hdr;
    logic [3:0][63:0] bch_word;
    logic [31:0]      hdr_word;
    logic [5:0]       idx_even;
    logic [5:0]       idx_odd;
    logic [3:0]       bit_even;
    logic [3:0]       bit_odd;
    logic [3:0][7:0]  ecc_sub_next;
    logic [7:0]       ecc_hdr_next;

    // one step of the reflected LFSR, data enters at the LSB end
    function automatic logic [7:0] next_ecc(input logic [7:0] ecc, input logic din);
        next_ecc = (ecc >> 1) ^ ((ecc[0] ^ din) ? `BCH_POLY : 8'd0);
    endfunction

    always_comb
    begin
        idx_even = {k, 1'b0};
        idx_odd  = {k, 1'b1};
        hdr_word = {ecc_hdr, pkt.header};
        for (int i = 0; i < 4; i++)
        begin
            bch_word[i] = {ecc_sub[i], pkt.sub[i]};
            bit_even[i] = bch_word[i][idx_even];
            bit_odd[i]  = bch_word[i][idx_odd];
            // two bits per cycle go out on each subpacket, so the parity steps twice
            ecc_sub_next[i] = next_ecc(next_ecc(ecc_sub[i], bit_even[i]), bit_odd[i]);
        end
        ecc_hdr_next = next_ecc(ecc_hdr, hdr_word[k]);
    end

    // the boundary pulse marks the last enabled cycle of a packet
    assign pkt.packet_next = pkt.enable && (k == LAST_K);

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            k       <= 5'd0;
            ecc_sub <= '0;
            ecc_hdr <= 8'd0;
        end
        else if (pkt.enable)
        begin
            k <= k + 5'd1;
            if (k == LAST_K)
            begin
                ecc_sub <= '0;
                ecc_hdr <= 8'd0;
            end
            else
            begin
                // parity covers the data bits only, never the parity being sent
                if (k < SUB_ECC_K)
                    ecc_sub <= ecc_sub_next;
                if (k < HDR_ECC_K)
                    ecc_hdr <= ecc_hdr_next;
            end
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (pkt.enable)
            data <= {bit_odd, bit_even, hdr_word[k]};
    end

endmodule

`default_nettype wire

// ==== terc4_encoder.sv ====
`default_nettype none
`timescale 1ns/1ps

module terc4_encoder
(
    input  logic       clk_pixel,
    input  logic       arst_n,
    input  logic       enable,
    input  logic [8:0] data,
    input  logic       hsync,
    input  logic       vsync,
    input  logic       first_bit,
    output logic [9:0] tmds_ch0,
    output logic [9:0] tmds_ch1,
    output logic [9:0] tmds_ch2,
    output logic       symbol_valid
);

    logic       enable_d1;
    logic [3:0] nib0;

    function automatic logic [9:0] terc4(input logic [3:0] nib);
        case (nib)
            4'b0000: terc4 = 10'b1010011100;
            4'b0001: terc4 = 10'b1001100011;
            4'b0010: terc4 = 10'b1011100100;
            4'b0011: terc4 = 10'b1011100010;
            4'b0100: terc4 = 10'b0101110001;
            4'b0101: terc4 = 10'b0100011110;
            4'b0110: terc4 = 10'b0110001110;
            4'b0111: terc4 = 10'b0100111100;
            4'b1000: terc4 = 10'b1011001100;
            4'b1001: terc4 = 10'b0100111001;
            4'b1010: terc4 = 10'b0110011100;
            4'b1011: terc4 = 10'b1011000110;
            4'b1100: terc4 = 10'b1010001110;
            4'b1101: terc4 = 10'b1001110001;
            4'b1110: terc4 = 10'b0101100011;
            default: terc4 = 10'b1011000011;
        endcase
    endfunction

    // bit 3 of channel 0 is low only on the first symbol of a packet
    assign nib0 = {~first_bit, data[0], vsync, hsync};

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            enable_d1    <= 1'b0;
            symbol_valid <= 1'b0;
        end
        else
        begin
            enable_d1    <= enable;
            symbol_valid <= enable_d1;
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        tmds_ch0 <= terc4(nib0);
        tmds_ch1 <= terc4(data[4:1]);
        tmds_ch2 <= terc4(data[8:5]);
    end

endmodule

`default_nettype wire

// ==== hdmi_island_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module hdmi_island_top
(
    input  logic       clk_pixel,
    input  logic       arst_n,
    input  logic       island_enable,
    input  logic       hsync,
    input  logic       vsync,
    input  logic       avi_request,
    input  logic [6:0] vic,
    input  logic [1:0] color_format,
    output logic [9:0] tmds_ch0,
    output logic [9:0] tmds_ch1,
    output logic [9:0] tmds_ch2,
    output logic       symbol_valid
);

    logic [8:0] data;
    logic       hsync_q;
    logic       vsync_q;
    logic       at_start;
    logic       first_bit;

    island_packet_if pkt ();

    assign pkt.enable = island_enable;

    // the next enabled cycle opens a packet after reset and after each boundary pulse,
    // so first_bit is registered alongside the data word it belongs to
    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            at_start  <= 1'b1;
            first_bit <= 1'b0;
        end
        else if (island_enable)
        begin
            at_start  <= pkt.packet_next;
            first_bit <= at_start;
        end
    end

    // sync levels take the same single stage as the serializer output
    always_ff @(posedge clk_pixel)
    begin
        hsync_q <= hsync;
        vsync_q <= vsync;
    end

    packet_selector u_selector
    (
        .clk_pixel    (clk_pixel),
        .arst_n       (arst_n),
        .avi_request  (avi_request),
        .vic          (vic),
        .color_format (color_format),
        .pkt          (pkt.source)
    );

    island_serializer u_serializer
    (
        .clk_pixel (clk_pixel),
        .arst_n    (arst_n),
        .pkt       (pkt.sink),
        .data      (data)
    );

    terc4_encoder u_encoder
    (
        .clk_pixel    (clk_pixel),
        .arst_n       (arst_n),
        .enable       (island_enable),
        .data         (data),
        .hsync        (hsync_q),
        .vsync        (vsync_q),
        .first_bit    (first_bit),
        .tmds_ch0     (tmds_ch0),
        .tmds_ch1     (tmds_ch1),
        .tmds_ch2     (tmds_ch2),
        .symbol_valid (symbol_valid)
    );

endmodule

`default_nettype wire

// ==== hdmi_island_chk.sv ====
`default_nettype none
`timescale 1ns/1ps

module hdmi_island_chk
(
    input logic       clk_pixel,
    input logic       arst_n,
    input logic       island_enable,
    input logic [9:0] tmds_ch0,
    input logic [9:0] tmds_ch1,
    input logic [9:0] tmds_ch2,
    input logic       symbol_valid
);

    // no symbol may be flagged while the design is held in reset
    a_reset_quiet: assert property (@(posedge clk_pixel) !arst_n |-> !symbol_valid)
        else $error("symbol_valid high during reset");

    a_known_symbols: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        symbol_valid |-> !$isunknown({tmds_ch0, tmds_ch1, tmds_ch2}))
        else $error("unknown TMDS symbol while symbol_valid is high");

    // serializer stage plus encoder stage between the enable level and the valid flag
    a_valid_delay: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        symbol_valid == $past(island_enable, 2))
        else $error("symbol_valid does not follow island_enable by two cycles");

endmodule

bind hdmi_island_top hdmi_island_chk u_chk
(
    .clk_pixel     (clk_pixel),
    .arst_n        (arst_n),
    .island_enable (island_enable),
    .tmds_ch0      (tmds_ch0),
    .tmds_ch1      (tmds_ch1),
    .tmds_ch2      (tmds_ch2),
    .symbol_valid  (symbol_valid)
);

`default_nettype wire

// ==== hdmi_island_tb.sv ====
`include "hdmi_island_config.svh"
`default_nettype none
`timescale 1ns/1ps

module hdmi_island_tb;

    localparam int WAIT_LIMIT = 20;

    logic             clk_pixel = 1'b0;
    logic             arst_n;
    logic             island_enable;
    logic             hsync;
    logic             vsync;
    logic             avi_request;
    logic [6:0]       vic;
    logic [1:0]       color_format;
    logic [9:0]       tmds_ch0;
    logic [9:0]       tmds_ch1;
    logic [9:0]       tmds_ch2;
    logic             symbol_valid;

    int               seed = 32'h4737_ecfb;
    int               errors = 0;
    int               tests_passed = 0;
    int               tests_failed = 0;
    logic [1:0]       sync_q[$];
    logic [31:0]      got_hdr;
    logic [3:0][63:0] got_sub;
    logic [31:0]      avi_hdr;
    logic [3:0][63:0] avi_sub;
    logic [6:0]       avi_vic;
    logic [1:0]       avi_cf;

    always #50 clk_pixel = ~clk_pixel;

    hdmi_island_top dut
    (
        .clk_pixel    (clk_pixel),
        .arst_n       (arst_n),
        .island_enable(island_enable),
        .hsync        (hsync),
        .vsync        (vsync),
        .avi_request  (avi_request),
        .vic          (vic),
        .color_format (color_format),
        .tmds_ch0     (tmds_ch0),
        .tmds_ch1     (tmds_ch1),
        .tmds_ch2     (tmds_ch2),
        .symbol_valid (symbol_valid)
    );

    // inverse of the TERC4 code table, bit 4 flags a symbol outside the table
    function automatic logic [4:0] terc4_decode(input logic [9:0] sym);
        case (sym)
            10'b1010011100: terc4_decode = 5'h00;
            10'b1001100011: terc4_decode = 5'h01;
            10'b1011100100: terc4_decode = 5'h02;
            10'b1011100010: terc4_decode = 5'h03;
            10'b0101110001: terc4_decode = 5'h04;
            10'b0100011110: terc4_decode = 5'h05;
            10'b0110001110: terc4_decode = 5'h06;
            10'b0100111100: terc4_decode = 5'h07;
            10'b1011001100: terc4_decode = 5'h08;
            10'b0100111001: terc4_decode = 5'h09;
            10'b0110011100: terc4_decode = 5'h0A;
            10'b1011000110: terc4_decode = 5'h0B;
            10'b1010001110: terc4_decode = 5'h0C;
            10'b1001110001: terc4_decode = 5'h0D;
            10'b0101100011: terc4_decode = 5'h0E;
            10'b1011000011: terc4_decode = 5'h0F;
            default:        terc4_decode = 5'h10;
        endcase
    endfunction

    // BCH parity over the first count bits, bit 0 enters first
    function automatic logic [7:0] bch_parity(input logic [55:0] bits, input int count);
        logic [7:0] r;
        logic       fb;
        int         i;
        r = 8'd0;
        for (i = 0; i < count; i++)
        begin
            fb = r[0] ^ bits[i];
            r  = {1'b0, r[7:1]};
            if (fb)
                r = r ^ `BCH_POLY;
        end
        return r;
    endfunction

    // AVI payload, PB0 is the byte that brings the sum of all InfoFrame bytes to zero
    function automatic logic [3:0][55:0] avi_payload(input logic [6:0] v, input logic [1:0] cf);
        logic [3:0][55:0] sub;
        logic [7:0]       sum;
        logic [7:0]       pb0;
        int               c;
        sub           = '0;
        sub[0][15:8]  = {1'b0, cf, 5'd0};
        sub[0][39:32] = {1'b0, v};
        sum           = `AVI_TYPE + `AVI_VERSION + `AVI_LENGTH + sub[0][15:8] + sub[0][39:32];
        pb0           = 8'd0;
        for (c = 0; c < 256; c++)
        begin
            if (8'(sum + 8'(c)) == 8'd0)
                pb0 = 8'(c);
        end
        sub[0][7:0]   = pb0;
        return sub;
    endfunction

    task automatic expect_equal(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("FAIL t=%0t %s: got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic request_avi(input logic [6:0] v, input logic [1:0] cf);
        @(posedge clk_pixel);
        #5;
        avi_request  = 1'b1;
        vic          = v;
        color_format = cf;
        @(posedge clk_pixel);
        #5;
        avi_request = 1'b0;
    endtask

    // drives 32 enabled cycles, optionally broken up by idle stretches
    task automatic drive_island(input logic gaps);
        logic [31:0] rnd;
        int          sent;
        int          gap_run;
        sent    = 0;
        gap_run = 0;
        while (sent < `ISLAND_CYCLES)
        begin
            @(posedge clk_pixel);
            #5;
            rnd   = $random(seed);
            hsync = rnd[0];
            vsync = rnd[1];
            if (gaps && rnd[3:2] == 2'd0 && gap_run < 6)
            begin
                island_enable = 1'b0;
                gap_run++;
            end
            else
            begin
                island_enable = 1'b1;
                sync_q.push_back({vsync, hsync});
                sent++;
                gap_run = 0;
            end
        end
        @(posedge clk_pixel);
        #5;
        island_enable = 1'b0;
    endtask

    task automatic collect_island;
        logic [4:0] n0;
        logic [4:0] n1;
        logic [4:0] n2;
        logic [1:0] sync_exp;
        int         got;
        int         idle;
        int         i;
        got  = 0;
        idle = 0;
        while (got < `ISLAND_CYCLES)
        begin
            @(negedge clk_pixel);
            if (symbol_valid !== 1'b1)
            begin
                idle++;
                if (idle > WAIT_LIMIT)
                begin
                    $display("timeout at t=%0t: symbol_valid did not rise", $time);
                    errors++;
                    break;
                end
            end
            else
            begin
                idle = 0;
                n0   = terc4_decode(tmds_ch0);
                n1   = terc4_decode(tmds_ch1);
                n2   = terc4_decode(tmds_ch2);
                if (n0[4] || n1[4] || n2[4])
                begin
                    $display("symbol %0d at t=%0t is not a TERC4 code", got, $time);
                    errors++;
                end
                if (sync_q.size() == 0)
                begin
                    $display("symbol emitted at t=%0t without an enabled cycle", $time);
                    errors++;
                end
                else
                begin
                    sync_exp = sync_q.pop_front();
                    expect_equal("tmds_ch0 sync bits", 64'(n0[1:0]), 64'(sync_exp));
                end
                // channel 0 bit 3 is low only on the first symbol of a packet
                expect_equal("tmds_ch0 bit 3", 64'(n0[3]), 64'(got != 0));
                got_hdr[got] = n0[2];
                for (i = 0; i < 4; i++)
                begin
                    got_sub[i][2 * got]     = n1[i];
                    got_sub[i][2 * got + 1] = n2[i];
                end
                got++;
            end
        end
    endtask

    task automatic run_island(input logic gaps);
        sync_q.delete();
        fork
            drive_island(gaps);
            collect_island();
        join
        // once the packet is out, the valid flag has to drop
        repeat (2)
        begin
            @(negedge clk_pixel);
            expect_equal("symbol_valid", 64'(symbol_valid), 64'd0);
        end
    endtask

    task automatic check_packet(input logic [23:0] exp_hdr, input logic [3:0][55:0] exp_sub);
        int i;
        expect_equal("header", 64'(got_hdr[23:0]), 64'(exp_hdr));
        for (i = 0; i < 4; i++)
            expect_equal($sformatf("subpacket %0d", i), 64'(got_sub[i][55:0]), 64'(exp_sub[i]));
    endtask

    task automatic check_ecc(input logic [31:0] hdr, input logic [3:0][63:0] sub);
        int i;
        expect_equal("header ECC", 64'(hdr[31:24]), 64'(bch_parity(56'(hdr[23:0]), 24)));
        for (i = 0; i < 4; i++)
            expect_equal($sformatf("subpacket %0d ECC", i), 64'(sub[i][63:56]),
                         64'(bch_parity(sub[i][55:0], 56)));
    endtask

    task automatic end_test(input string name, input int err_before);
        if (errors == err_before)
        begin
            tests_passed++;
            $display("test %s: passed", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    initial
    begin
        logic [31:0] rnd;
        logic [7:0]  sum;
        int          mark;
        int          i;
        arst_n        = 1'b0;
        island_enable = 1'b0;
        hsync         = 1'b0;
        vsync         = 1'b0;
        avi_request   = 1'b0;
        vic           = 7'd0;
        color_format  = 2'd0;

        mark = errors;
        repeat (8)
        begin
            @(negedge clk_pixel);
            expect_equal("symbol_valid", 64'(symbol_valid), 64'd0);
        end
        @(posedge clk_pixel);
        #5;
        arst_n = 1'b1;
        repeat (4)
        begin
            @(negedge clk_pixel);
            expect_equal("symbol_valid", 64'(symbol_valid), 64'd0);
        end
        @(posedge clk_pixel);
        #5;
        island_enable = 1'b1;
        repeat (2)
        begin
            @(negedge clk_pixel);
            expect_equal("symbol_valid", 64'(symbol_valid), 64'd0);
        end
        @(negedge clk_pixel);
        expect_equal("symbol_valid", 64'(symbol_valid), 64'd1);
        // run the opened packet to its end so later packets start at index 0
        repeat (30) @(posedge clk_pixel);
        #5;
        island_enable = 1'b0;
        repeat (3) @(negedge clk_pixel);
        end_test("reset_state", mark);

        mark = errors;
        run_island(1'b0);
        check_packet(24'd0, '0);
        check_ecc(got_hdr, got_sub);
        end_test("null_packet", mark);

        mark = errors;
        rnd     = $random(seed);
        avi_vic = rnd[6:0];
        avi_cf  = rnd[9:8];
        request_avi(avi_vic, avi_cf);
        // the slot chosen before the request still goes out as a null packet
        run_island(1'b0);
        check_packet(24'd0, '0);
        run_island(1'b0);
        check_packet(24'h0D0282, avi_payload(avi_vic, avi_cf));
        sum = got_hdr[7:0] + got_hdr[15:8] + got_hdr[23:16];
        for (i = 0; i < 7; i++)
            sum = sum + got_sub[0][8 * i +: 8];
        expect_equal("InfoFrame byte sum", 64'(sum), 64'd0);
        avi_hdr = got_hdr;
        avi_sub = got_sub;
        run_island(1'b0);
        check_packet(24'd0, '0);
        end_test("avi_infoframe", mark);

        mark = errors;
        check_ecc(avi_hdr, avi_sub);
        end_test("avi_ecc", mark);

        mark = errors;
        run_island(1'b0);
        check_packet(24'd0, '0);
        end_test("sync_passthrough", mark);

        mark = errors;
        request_avi(avi_vic, avi_cf);
        run_island(1'b1);
        check_packet(24'd0, '0);
        run_island(1'b1);
        expect_equal("gapped header", 64'(got_hdr), 64'(avi_hdr));
        for (i = 0; i < 4; i++)
            expect_equal($sformatf("gapped subpacket %0d", i), got_sub[i], avi_sub[i]);
        end_test("enable_gaps", mark);

        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
hdmi_island_pkg.sv
island_packet_if.sv
packet_selector.sv
island_serializer.sv
terc4_encoder.sv
hdmi_island_top.sv
hdmi_island_chk.sv
hdmi_island_tb.sv

// ==== Makefile ====
# Verilator flow for the HDMI data island testbench

VERILATOR  ?= verilator
TOP        ?= hdmi_island_tb
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_FLAGS  ?= --binary --timing --assert
PASS_TEXT  ?= Simulation completed successfully

SOURCES := $(wildcard *.sv) $(wildcard *.svh) $(FLIST)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
